/* sources.f */
hw/noc_pkg.sv
hw/node_cfg_regs.sv
hw/route_compute.sv
hw/flit_fifo.sv
hw/out_arbiter.sv
hw/mesh_router.sv
dv/mesh_router_asserts.sv
dv/mesh_router_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the mesh router testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
   --top-module mesh_router_tb -o mesh_router_sim > build.log 2>&1 \
   || { cat build.log; echo "verilator build error"; exit 1; }
./obj_dir/mesh_router_sim > sim.log 2>&1
cat sim.log
# pass needs the pass line and no assertion error text
grep -q "^Regression passed$" sim.log && ! grep -q "%Error" sim.log \
   && { echo "run ok"; exit 0; } \
   || { echo "run not ok"; exit 1; }

/* dv/mesh_router_tb.sv */
`timescale 1ns/1ps

module mesh_router_tb import noc_pkg::*; ();

   logic       clk;
   logic       rst;
   port_vec_t  in_valid;
   flit_t      in_flit [NUM_PORTS];
   port_vec_t  out_valid;
   flit_t      out_flit [NUM_PORTS];
   logic       cfg_we;
   cfg_addr_t  cfg_addr;
   logic [7:0] cfg_wdata;
   logic [7:0] cfg_rdata;

   // scoreboard entries hold out_port*256 + flit
   int     pending [$];
   bit     flood;
   int     flood_sent [NUM_PORTS];
   int     flood_got [NUM_PORTS];
   coord_t cur_x;
   coord_t cur_y;
   int     seed_val;
   int     drops;
   int     got_total;
   int     wait_n;
   int     exp_flags;

   mesh_router DUT (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_flit   (in_flit),
      .out_valid (out_valid),
      .out_flit  (out_flit),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////
   task automatic abort_run();
      $display("Regression failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_val(string name, int exp, int act);
      if (exp !== act) begin
         $display("[ERROR] %0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
         abort_run();
      end
   endtask

   // expected output port from dest and node coords
   function automatic int xy_dest_port(coord_t dx, coord_t dy, coord_t nx, coord_t ny);
      if (dx > nx) return PORT_EAST;
      if (dx < nx) return PORT_WEST;
      if (dy > ny) return PORT_SOUTH;
      if (dy < ny) return PORT_NORTH;
      return PORT_LOCAL;
   endfunction

   task automatic write_reg(cfg_addr_t addr, logic [7:0] data);
      cfg_we    = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = data;
      @(negedge clk);
      cfg_we = 1'b0;
   endtask

   // address set on one falling edge, data sampled on the next
   task automatic read_reg(cfg_addr_t addr, string name, int exp);
      cfg_addr = addr;
      @(negedge clk);
      check_val(name, exp, int'(cfg_rdata));
   endtask

   task automatic set_coords(coord_t x, coord_t y);
      write_reg(ADDR_COORD, {4'b0, y, x});
      cur_x = x;
      cur_y = y;
      read_reg(ADDR_COORD, "cfg_rdata coord", int'({y, x}));
   endtask

   // one cycle of flits on the ports in which
   // negative fixed_dest gives each flit a random dest
   task automatic launch(port_vec_t which, int fixed_dest);
      flit_t f;
      int    port;
      for (int i = 0; i < NUM_PORTS; i++) begin
         f[3:0] = (fixed_dest < 0) ? 4'($urandom) : 4'(fixed_dest);
         f[7]   = 1'($urandom);
         // source tag in payload
         f[6:4] = 3'(i);
         in_flit[i] = f;
         if (which[i]) begin
            port = xy_dest_port(f[1:0], f[3:2], cur_x, cur_y);
            if (flood) flood_sent[i]++;
            else pending.push_back(port * 256 + int'(f));
         end
      end
      in_valid = which;
      @(negedge clk);
      in_valid = '0;
   endtask

   task automatic match_delivery(int port, flit_t f);
      int idx;
      idx = -1;
      foreach (pending[k]) begin
         if (idx < 0 && pending[k] == port * 256 + int'(f)) idx = k;
      end
      if (idx < 0) begin
         $display("unexpected flit 0x%0h delivered on output %0d at %0t", f, port, $time);
         abort_run();
      end
      pending.delete(idx);
   endtask

   task automatic wait_drained(int limit, string what);
      int n;
      n = 0;
      while (pending.size() != 0 && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (pending.size() != 0) begin
         $display("timeout, %0d flits never delivered in %s", pending.size(), what);
         abort_run();
      end
   endtask

   // outputs are stable at the falling edge
   always @(negedge clk) begin
      if (!rst) begin
         for (int p = 0; p < NUM_PORTS; p++) begin
            if (out_valid[p] && flood) flood_got[out_flit[p][6:4]]++;
            else if (out_valid[p]) match_delivery(p, out_flit[p]);
         end
      end
   end

   // hard limit on the whole run
   initial begin
      repeat (5000) @(posedge clk);
      $display("simulation ran too long, test sequence never finished");
      abort_run();
   end

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////
   initial begin
      seed_val  = $urandom(75894);
      rst       = 1'b1;
      in_valid  = '0;
      cfg_we    = 1'b0;
      cfg_addr  = '0;
      cfg_wdata = '0;
      flood     = 1'b0;
      cur_x     = '0;
      cur_y     = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
         in_flit[i]    = '0;
         flood_sent[i] = 0;
         flood_got[i]  = 0;
      end
      repeat (10) @(negedge clk);
      rst = 1'b0;

      // idle after reset
      repeat (4) begin
         @(negedge clk);
         check_val("out_valid", 0, int'(out_valid));
      end
      read_reg(ADDR_COORD, "cfg_rdata coord", 0);
      read_reg(ADDR_DROP_CNT, "cfg_rdata drop_cnt", 0);
      read_reg(ADDR_DROP_FLAGS, "cfg_rdata drop_flags", 0);

      // random single flits at node 1,2
      set_coords(2'd1, 2'd2);
      repeat (6) begin
         launch('1, -1);
         wait_drained(30, "node 1,2 traffic");
      end

      // node moved to 3,0 with local ejection included
      set_coords(2'd3, 2'd0);
      launch('1, 4'b0011);
      wait_drained(30, "local delivery at 3,0");
      repeat (6) begin
         launch('1, -1);
         wait_drained(30, "node 3,0 traffic");
      end

      // all five inputs to one output in one cycle
      repeat (3) begin
         launch('1, int'($urandom_range(15)));
         wait_drained(8, "five way contention");
      end
      repeat (4) @(negedge clk);

      // flood the local output until the fifos overflow
      flood = 1'b1;
      repeat (12) launch('1, int'({cur_y, cur_x}));
      cfg_addr = ADDR_DROP_CNT;
      @(negedge clk);
      drops     = int'(cfg_rdata);
      got_total = 0;
      wait_n    = 0;
      while (got_total + drops != 60 && wait_n < 60) begin
         @(negedge clk);
         wait_n++;
         got_total = 0;
         foreach (flood_got[i]) got_total += flood_got[i];
      end
      if (got_total + drops != 60) begin
         $display("timeout, flood traffic never accounted for, %0d delivered", got_total);
         abort_run();
      end
      repeat (5) @(negedge clk);
      got_total = 0;
      foreach (flood_got[i]) got_total += flood_got[i];
      check_val("delivered + drop_cnt", 60, got_total + drops);
      // a flag for each source that lost a flit
      exp_flags = 0;
      for (int i = 0; i < NUM_PORTS; i++) begin
         if (flood_got[i] < flood_sent[i]) exp_flags |= (1 << i);
      end
      read_reg(ADDR_DROP_FLAGS, "cfg_rdata drop_flags", exp_flags);
      flood = 1'b0;

      // clear counter and flags
      write_reg(ADDR_DROP_CNT, 8'h00);
      write_reg(ADDR_DROP_FLAGS, 8'h1f);
      read_reg(ADDR_DROP_CNT, "cfg_rdata drop_cnt", 0);
      read_reg(ADDR_DROP_FLAGS, "cfg_rdata drop_flags", 0);

      repeat (4) @(negedge clk);
      $display("Regression passed");
      $finish;
   end

endmodule

/* dv/mesh_router_asserts.sv */
`timescale 1ns/1ps

module mesh_router_asserts import noc_pkg::*; (
   input logic      clk,
   input logic      rst,
   input port_vec_t out_valid,
   input flit_t     out_flit [NUM_PORTS],
   input coord_t    node_x,
   input coord_t    node_y
);

   // xy rule, x first, y grows southward
   function automatic port_vec_t xy_select(flit_t f, coord_t nx, coord_t ny);
      coord_t dx;
      coord_t dy;
      dx = f[DEST_X_LSB +: COORD_W];
      dy = f[DEST_Y_LSB +: COORD_W];
      if (dx > nx) return port_vec_t'(1 << PORT_EAST);
      if (dx < nx) return port_vec_t'(1 << PORT_WEST);
      if (dy > ny) return port_vec_t'(1 << PORT_SOUTH);
      if (dy < ny) return port_vec_t'(1 << PORT_NORTH);
      return port_vec_t'(1 << PORT_LOCAL);
   endfunction

   ////////////////////////////////////////////////////////////
   // reset state
   ////////////////////////////////////////////////////////////
   a_reset_idle: assert property (@(posedge clk)
      rst |=> (out_valid == '0 && node_x == '0 && node_y == '0))
      else $error("router outputs or coordinates not cleared by reset");

   ////////////////////////////////////////////////////////////
   // per output legality
   ////////////////////////////////////////////////////////////
   for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
      // grant was made one cycle earlier, so route against past coords
      a_route: assert property (@(posedge clk) disable iff (rst)
         out_valid[p] |-> xy_select(out_flit[p], $past(node_x), $past(node_y))
                          == port_vec_t'(1 << p))
         else $error("flit %0h left on output %0d against the xy rule", out_flit[p], p);
      // no x payload while valid
      a_known: assert property (@(posedge clk) disable iff (rst)
         out_valid[p] |-> !$isunknown(out_flit[p]))
         else $error("unknown flit bits on valid output %0d", p);
   end

endmodule

bind mesh_router mesh_router_asserts u_asserts (
   .clk       (clk),
   .rst       (rst),
   .out_valid (out_valid),
   .out_flit  (out_flit),
   .node_x    (node_x),
   .node_y    (node_y)
);

/* hw/mesh_router.sv */
`timescale 1ns/1ps

module mesh_router import noc_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   // link side
   input  port_vec_t  in_valid,
   input  flit_t      in_flit [NUM_PORTS],
   output port_vec_t  out_valid,
   output flit_t      out_flit [NUM_PORTS],
   // config bus
   input  logic       cfg_we,
   input  cfg_addr_t  cfg_addr,
   input  logic [7:0] cfg_wdata,
   output logic [7:0] cfg_rdata
);

   // per input port
   flit_t     head_flit [NUM_PORTS];
   port_vec_t not_empty;
   port_vec_t drop;
   port_vec_t pop;
   port_vec_t route [NUM_PORTS];
   // per output port
   port_vec_t req   [NUM_PORTS];
   port_vec_t grant [NUM_PORTS];

   coord_t    node_x;
   coord_t    node_y;

   ////////////////////////////////////////////////////////////
   // config block
   ////////////////////////////////////////////////////////////
   node_cfg_regs u_cfg (
      .clk       (clk),
      .rst       (rst),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .drop      (drop),
      .node_x    (node_x),
      .node_y    (node_y),
      .cfg_rdata (cfg_rdata)
   );

   ////////////////////////////////////////////////////////////
   // input side, fifo then route
   ////////////////////////////////////////////////////////////
   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
      flit_fifo u_fifo (
         .clk       (clk),
         .rst       (rst),
         .push      (in_valid[i]),
         .push_flit (in_flit[i]),
         .pop       (pop[i]),
         .head_flit (head_flit[i]),
         .not_empty (not_empty[i]),
         .drop      (drop[i])
      );

      route_compute u_route (
         .dest_flit (head_flit[i]),
         .node_x    (node_x),
         .node_y    (node_y),
         .route     (route[i])
      );
   end

   // req[p][i], input i wants output p
   // pop[i], any output granted input i
   always_comb begin
      pop = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
         for (int i = 0; i < NUM_PORTS; i++) begin
            req[p][i] = not_empty[i] & route[i][p];
         end
         pop = pop | grant[p];
      end
   end

   ////////////////////////////////////////////////////////////
   // output side, one arbiter per port
   ////////////////////////////////////////////////////////////
   for (genvar p = 0; p < NUM_PORTS; p++) begin : g_out
      out_arbiter u_arb (
         .clk       (clk),
         .rst       (rst),
         .req       (req[p]),
         .cand_flit (head_flit),
         .grant     (grant[p]),
         .out_valid (out_valid[p]),
         .out_flit  (out_flit[p])
      );
   end

endmodule

/* hw/out_arbiter.sv */
`timescale 1ns/1ps

module out_arbiter import noc_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  port_vec_t req,
   input  flit_t     cand_flit [NUM_PORTS],
   output port_vec_t grant,
   output logic      out_valid,
   output flit_t     out_flit
);

   // one-hot, marks the port with highest priority
   port_vec_t                prio;
   logic [2*NUM_PORTS-1:0]   req_dbl;
   logic [2*NUM_PORTS-1:0]   gnt_dbl;
   flit_t                    sel_flit;

   ////////////////////////////////////////////////////////////
   // round robin grant
   ////////////////////////////////////////////////////////////
   // doubled request vector so the search wraps past the top port
   assign req_dbl = {req, req};
   // subtract borrows up to first requester at or above prio
   assign gnt_dbl = req_dbl & ~(req_dbl - {{NUM_PORTS{1'b0}}, prio});
   assign grant   = gnt_dbl[2*NUM_PORTS-1:NUM_PORTS] | gnt_dbl[NUM_PORTS-1:0];

   // pointer moves one past the winner
   always_ff @(posedge clk) begin
      if (rst) begin
         prio <= port_vec_t'(1);
      end else if (|grant) begin
         prio <= {grant[NUM_PORTS-2:0], grant[NUM_PORTS-1]};
      end
   end

   // and-or mux over the candidates
   always_comb begin
      sel_flit = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
         if (grant[i]) begin
            sel_flit = sel_flit | cand_flit[i];
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // output register
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= |grant;
      end
   end

   // payload only, valid qualifies it
   always_ff @(posedge clk) begin
      out_flit <= sel_flit;
   end

endmodule

/* hw/flit_fifo.sv */
`timescale 1ns/1ps

module flit_fifo import noc_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  logic  push,
   input  flit_t push_flit,
   input  logic  pop,
   output flit_t head_flit,
   output logic  not_empty,
   output logic  drop
);

   flit_t                 mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_PTR_W:0]   count;
   logic                  full;
   logic                  do_push;
   logic                  do_pop;

   assign full      = (count == (FIFO_PTR_W+1)'(FIFO_DEPTH));
   assign not_empty = (count != '0);

   // a pop frees the slot on the same edge
   assign do_pop  = pop && not_empty;
   assign do_push = push && (!full || do_pop);
   // lost flit, counted in cfg block
   assign drop    = push && full && !do_pop;

   // combinational head read
   assign head_flit = mem[rd_ptr];

   // storage
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_flit;
      end
   end

   ////////////////////////////////////////////////////////////
   // pointers and occupancy, wrap is natural at depth 4
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + (FIFO_PTR_W+1)'(do_push) - (FIFO_PTR_W+1)'(do_pop);
      end
   end

endmodule

/* hw/route_compute.sv */
`timescale 1ns/1ps

module route_compute import noc_pkg::*; (
   input  flit_t     dest_flit,
   input  coord_t    node_x,
   input  coord_t    node_y,
   output port_vec_t route
);

   coord_t dest_x;
   coord_t dest_y;

   // destination fields from the low nibble
   assign dest_x = dest_flit[DEST_X_LSB +: COORD_W];
   assign dest_y = dest_flit[DEST_Y_LSB +: COORD_W];

   ////////////////////////////////////////////////////////////
   // dimension ordered xy, x first then y
   ////////////////////////////////////////////////////////////
   always_comb begin
      route = '0;
      if (dest_x > node_x) begin
         route[PORT_EAST] = 1'b1;
      end else if (dest_x < node_x) begin
         route[PORT_WEST] = 1'b1;
      end else if (dest_y > node_y) begin
         // y grows toward south
         route[PORT_SOUTH] = 1'b1;
      end else if (dest_y < node_y) begin
         route[PORT_NORTH] = 1'b1;
      end else begin
         // arrived, eject locally
         route[PORT_LOCAL] = 1'b1;
      end
   end

endmodule

/* hw/node_cfg_regs.sv */
`timescale 1ns/1ps

module node_cfg_regs import noc_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      cfg_we,
   input  cfg_addr_t cfg_addr,
   input  logic [7:0] cfg_wdata,
   input  port_vec_t drop,
   output coord_t    node_x,
   output coord_t    node_y,
   output logic [7:0] cfg_rdata
);

   cnt_t            drop_cnt;
   port_vec_t       drop_flags;
   logic [3:0]      drop_num;
   logic [CNT_W:0]  cnt_sum;

   // number of ports dropping this cycle
   function automatic logic [3:0] count_ones(port_vec_t v);
      logic [3:0] n;
      n = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
         n = n + 4'(v[i]);
      end
      return n;
   endfunction

   assign drop_num = count_ones(drop);
   // one spare bit to catch overflow
   assign cnt_sum  = {1'b0, drop_cnt} + (CNT_W+1)'(drop_num);

   always_ff @(posedge clk) begin
      if (rst) begin
         node_x     <= '0;
         node_y     <= '0;
         drop_cnt   <= '0;
         drop_flags <= '0;
      end else begin
         if (cfg_we && cfg_addr == ADDR_COORD) begin
            node_x <= cfg_wdata[COORD_W-1:0];
            node_y <= cfg_wdata[2*COORD_W-1:COORD_W];
         end
         // any write clears, drops landing on the same edge still count
         if (cfg_we && cfg_addr == ADDR_DROP_CNT) begin
            drop_cnt <= CNT_W'(drop_num);
         end else if (cnt_sum[CNT_W]) begin
            drop_cnt <= '1;
         end else begin
            drop_cnt <= cnt_sum[CNT_W-1:0];
         end
         // write one to clear, new drop wins
         if (cfg_we && cfg_addr == ADDR_DROP_FLAGS) begin
            drop_flags <= (drop_flags & ~cfg_wdata[NUM_PORTS-1:0]) | drop;
         end else begin
            drop_flags <= drop_flags | drop;
         end
      end
   end

   // read mux, unmapped address reads zero
   always_comb begin
      case (cfg_addr)
         ADDR_COORD:      cfg_rdata = {{(8-2*COORD_W){1'b0}}, node_y, node_x};
         ADDR_DROP_CNT:   cfg_rdata = drop_cnt;
         ADDR_DROP_FLAGS: cfg_rdata = {{(8-NUM_PORTS){1'b0}}, drop_flags};
         default:         cfg_rdata = '0;
      endcase
   end

endmodule

/* hw/noc_pkg.sv */
package noc_pkg;

   ////////////////////////////////////////////////////////////
   // router shape and port numbering
   ////////////////////////////////////////////////////////////
   localparam int NUM_PORTS  = 5;
   // bit positions in every per-port vector
   localparam int PORT_LOCAL = 0;
   localparam int PORT_EAST  = 1;
   localparam int PORT_NORTH = 2;
   localparam int PORT_WEST  = 3;
   localparam int PORT_SOUTH = 4;

   // flit layout, dest x/y in low nibble, payload above
   localparam int COORD_W    = 2;
   localparam int FLIT_W     = 8;
   localparam int DEST_X_LSB = 0;
   localparam int DEST_Y_LSB = 2;

   // input buffering
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

   // config bus
   localparam int CFG_ADDR_W = 2;
   localparam int CNT_W      = 8;

   typedef logic [FLIT_W-1:0]     flit_t;
   typedef logic [COORD_W-1:0]    coord_t;
   typedef logic [NUM_PORTS-1:0]  port_vec_t;
   typedef logic [CNT_W-1:0]      cnt_t;
   typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;

   localparam cfg_addr_t ADDR_COORD      = 2'd0;
   localparam cfg_addr_t ADDR_DROP_CNT   = 2'd1;
   localparam cfg_addr_t ADDR_DROP_FLAGS = 2'd2;

endpackage
